// ==== sim/sched_cases.txt ====
# kind (rand bulk both refresh), write flag, address (hex), mask (hex), second address for both
# last column is the expected command letters: A ACTV, R READ, W WRTE, P PRCH, F ARSR
rand    0 0001234 f 0000000 AR
rand    1 0001250 5 0000000 W
bulk    1 0001300 a 0000000 W
bulk    0 0042a10 0 0000000 PAR
refresh 0 0000000 0 0000000 PF
rand    0 0042a10 7 0000000 AR
refresh 0 0000000 0 0000000 PF
refresh 0 0000000 0 0000000 F
both    1 3fffe00 3 3fffe04 AWW
both    0 0000200 f 0000400 PARPAR
rand    1 0000410 c 0000000 W
bulk    0 1555555 0 0000000 PAR
refresh 0 0000000 0 0000000 PF
both    1 2aaaaaa 9 0abcdef AWPAW
rand    0 0abcdef 0 0000000 R
refresh 0 0000000 0 0000000 PF

// ==== flist.f ====
design/sdram_sched_pkg.sv
design/sdram_req_if.sv
design/request_select.sv
design/cmd_sequencer.sv
design/cmd_timing_guard.sv
design/cmd_output.sv
design/sdram_sched_top.sv
sim/tb_sdram_sched.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f flist.f --top-module tb_sdram_sched -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && exit 1 || exit 0

// ==== sim/tb_sdram_sched.sv ====
module tb_sdram_sched;

  timeunit 1ns;
  timeprecision 100ps;

  import sdram_sched_pkg::*;

  typedef struct packed {
    sdram_cmd_e  cmd;
    sdram_addr_t addr;
    bank_t       bank;
    mask_t       mask;
    logic [1:0]  grant;            // Bit 1 bulk, bit 0 random
  } cmd_rec_t;

  logic              INPUT_CLK;
  logic              RST;
  logic              refresh_strobe;
  logic              rand_req;
  logic              rand_we;
  logic [ADDR_W-1:0] rand_addr;
  mask_t             rand_mask;
  logic              bulk_req;
  logic              bulk_we;
  logic [ADDR_W-1:0] bulk_addr;
  mask_t             bulk_mask;
  sdram_cmd_e        command;
  sdram_addr_t       address;
  bank_t             bank;
  mask_t             we_array;
  logic              grant_rand;
  logic              grant_bulk;

  string             kind_q[$];
  string             expect_q[$];
  logic              we_q[$];
  logic [ADDR_W-1:0] addr_q[$];
  logic [ADDR_W-1:0] addr2_q[$];
  mask_t             mask_q[$];
  cmd_rec_t          exp_q[$];
  cmd_rec_t          obs_q[$];

  logic        model_open = 1'b0;
  page_t       model_page = '0;
  logic [31:0] lfsr = 32'h738e_e97d;
  logic        monitor_on = 1'b0;
  sdram_cmd_e  last_cmd = NOOP;
  int          last_cycle = -1;
  int          cycle_cnt = 0;
  int          cycle_limit = 0;
  int          error_count = 0;
  int          pass_cases = 0;
  int          fail_cases = 0;
  int          grants_rand_seen = 0;
  int          grants_bulk_seen = 0;

  sdram_sched_top DUT (
    .INPUT_CLK (INPUT_CLK), .RST (RST), .refresh_strobe (refresh_strobe),
    .rand_req (rand_req), .rand_we (rand_we), .rand_addr (rand_addr), .rand_mask (rand_mask),
    .bulk_req (bulk_req), .bulk_we (bulk_we), .bulk_addr (bulk_addr), .bulk_mask (bulk_mask),
    .command (command), .address (address), .bank (bank), .we_array (we_array),
    .grant_rand (grant_rand), .grant_bulk (grant_bulk)
  );

  initial
  begin
    INPUT_CLK = 1'b0;
    forever #2 INPUT_CLK = ~INPUT_CLK;
  end

  function automatic logic lfsr_step();
    logic lsb;
    lsb  = lfsr[0];
    lfsr = lfsr >> 1;
    if (lsb)
      lfsr = lfsr ^ 32'h8020_0003;  // Taps 32 22 2 1
    return lsb;
  endfunction

  function automatic int gap_of(input sdram_cmd_e c);
    case (c)
      ACTV:    return int'(GAP_ACTV);
      READ:    return int'(GAP_READ);
      WRTE:    return int'(GAP_WRTE);
      PRCH:    return int'(GAP_PRCH);
      ARSR:    return int'(GAP_ARSR);
      default: return 0;
    endcase
  endfunction

  function automatic string letter_of(input sdram_cmd_e c);
    case (c)
      ACTV:    return "A";
      READ:    return "R";
      WRTE:    return "W";
      PRCH:    return "P";
      ARSR:    return "F";
      default: return "?";
    endcase
  endfunction

  task automatic report_value(input string sig, input logic [31:0] exp_v,
                              input logic [31:0] got_v);
    $display("ERROR at %0t ns: %s expected %h, got %h", $time, sig, exp_v, got_v);
    error_count++;
  endtask

  // --------------------------------------------------
  // Reference model of the command rules
  // --------------------------------------------------
  task automatic push_expect(input sdram_cmd_e c, input sdram_addr_t a, input bank_t b,
                             input mask_t m, input logic [1:0] g, inout string seq);
    exp_q.push_back({c, a, b, m, g});
    seq = {seq, letter_of(c)};
  endtask

  task automatic predict_access(input logic from_bulk, input logic we,
                                input logic [ADDR_W-1:0] addr, input mask_t m,
                                inout string seq);
    row_t  r;
    bank_t b;
    col_t  c;
    r = addr[25:12];
    b = addr[11:9];
    c = addr[8:0];
    if (model_open && model_page != {r, b})
    begin
      push_expect(PRCH, 14'h0400, 3'd0, m, 2'd0, seq);  // Close the other page
      model_open = 1'b0;
    end
    if (!model_open)
    begin
      push_expect(ACTV, r, b, m, 2'd0, seq);
      model_open = 1'b1;
      model_page = {r, b};
    end
    push_expect(we ? WRTE : READ, {4'b0000, c, 1'b0}, b, m, from_bulk ? 2'd2 : 2'd1, seq);
  endtask

  task automatic predict_refresh(inout string seq);
    if (model_open)
      push_expect(PRCH, 14'h0400, 3'd0, 4'h0, 2'd0, seq);
    push_expect(ARSR, 14'h0000, 3'd0, 4'h0, 2'd0, seq);
    model_open = 1'b0;
  endtask

  // --------------------------------------------------
  // Output monitor, sampled away from the rising edge
  // --------------------------------------------------
  always @(negedge INPUT_CLK)
  begin
    cmd_rec_t rec;
    if (monitor_on)
    begin
      if (grant_rand && grant_bulk)
      begin
        $display("Both grants were high together at %0t ns", $time);
        error_count++;
      end
      if (command != NOOP)
      begin
        if (last_cycle >= 0 && cycle_cnt - last_cycle < gap_of(last_cmd))
        begin
          $display("%s came %0d cycles after %s at %0t ns, below the gap of %0d",
                   command.name(), cycle_cnt - last_cycle, last_cmd.name(), $time,
                   gap_of(last_cmd));
          error_count++;
        end
        last_cycle = cycle_cnt;
        last_cmd   = command;
        rec        = {command, address, bank, we_array, grant_bulk, grant_rand};
        obs_q.push_back(rec);
      end
      else if (grant_rand || grant_bulk)
      begin
        $display("A grant came without READ or WRTE at %0t ns", $time);
        error_count++;
      end
      if (grant_rand)
        grants_rand_seen++;
      if (grant_bulk)
        grants_bulk_seen++;
    end
  end

  task automatic load_cases(output bit ok);
    int                fd;
    int                n;
    int                we_v;
    string             line;
    string             kind;
    string             seq;
    logic [ADDR_W-1:0] a1;
    logic [ADDR_W-1:0] a2;
    mask_t             m;
    fd = $fopen("sim/sched_cases.txt", "r");
    if (fd != 0)
    begin
      while (!$feof(fd))
      begin
        line = "";
        n    = $fgets(line, fd);
        if (n > 1 && line.getc(0) != 8'h23)  // Skip blank and # lines
        begin
          n = $sscanf(line, "%s %d %h %h %h %s", kind, we_v, a1, m, a2, seq);
          if (n == 6)
          begin
            kind_q.push_back(kind);
            we_q.push_back(we_v[0]);
            addr_q.push_back(a1);
            mask_q.push_back(m);
            addr2_q.push_back(a2);
            expect_q.push_back(seq);
          end
          else
          begin
            $display("Cases file has a line that cannot be read: %s", line);
            error_count++;
          end
        end
      end
      $fclose(fd);
    end
    ok = (fd != 0) && (kind_q.size() > 0);
  endtask

  task automatic run_case(input int idx);
    string kind;
    string seq;
    string got;
    int    errs_before;
    int    idle;
    bit    use_rand;
    bit    use_bulk;
    bit    done;
    kind        = kind_q[idx];
    seq         = "";
    got         = "";
    errs_before = error_count;
    use_bulk    = (kind == "bulk") || (kind == "both");
    use_rand    = (kind == "rand") || (kind == "both");
    exp_q.delete();
    if (kind == "refresh")
      predict_refresh(seq);
    if (use_bulk)
      predict_access(1'b1, we_q[idx], addr_q[idx], mask_q[idx], seq);
    if (use_rand)
      predict_access(1'b0, we_q[idx], use_bulk ? addr2_q[idx] : addr_q[idx], mask_q[idx], seq);
    if (seq != expect_q[idx])
    begin
      $display("Cases file line %0d lists %s but the command rules give %s",
               idx + 1, expect_q[idx], seq);
      error_count++;
    end
    grants_rand_seen = 0;
    grants_bulk_seen = 0;
    @(posedge INPUT_CLK);
    if (kind == "refresh")
      refresh_strobe <= ~refresh_strobe;       // One toggle, one refresh
    if (use_bulk)
    begin
      bulk_req  <= 1'b1;
      bulk_we   <= we_q[idx];
      bulk_addr <= addr_q[idx];
      bulk_mask <= mask_q[idx];
    end
    if (use_rand)
    begin
      rand_req  <= 1'b1;
      rand_we   <= we_q[idx];
      rand_addr <= use_bulk ? addr2_q[idx] : addr_q[idx];
      rand_mask <= mask_q[idx];
    end
    done = 1'b0;
    while (!done)
    begin
      @(posedge INPUT_CLK);
      if (grants_bulk_seen > 0)
        bulk_req <= 1'b0;                      // Drop after own grant
      if (grants_rand_seen > 0)
        rand_req <= 1'b0;
      if (kind == "refresh")
        done = (obs_q.size() > 0) && (obs_q[$].cmd == ARSR);
      else
        done = (!use_bulk || grants_bulk_seen > 0) && (!use_rand || grants_rand_seen > 0);
    end
    foreach (obs_q[i])
      got = {got, letter_of(obs_q[i].cmd)};
    if (got != expect_q[idx])
    begin
      $display("ERROR at %0t ns: command sequence expected %s, got %s",
               $time, expect_q[idx], got);
      error_count++;
    end
    else
    begin
      for (int i = 0; i < obs_q.size() && i < exp_q.size(); i++)
      begin
        if (obs_q[i].addr != exp_q[i].addr)
          report_value("address", 32'(exp_q[i].addr), 32'(obs_q[i].addr));
        if (obs_q[i].bank != exp_q[i].bank)
          report_value("bank", 32'(exp_q[i].bank), 32'(obs_q[i].bank));
        if (obs_q[i].grant != exp_q[i].grant)
          report_value("grant_bulk,grant_rand", 32'(exp_q[i].grant), 32'(obs_q[i].grant));
        if (exp_q[i].cmd == WRTE && obs_q[i].mask != exp_q[i].mask)
          report_value("we_array", 32'(exp_q[i].mask), 32'(obs_q[i].mask));
      end
    end
    if (error_count == errs_before)
      pass_cases++;
    else
      fail_cases++;
    $display("Case %0d %s %s: %s", idx + 1, kind, got,
             (error_count == errs_before) ? "pass" : "fail");
    obs_q.delete();                            // Later commands land in the next case
    idle = 0;
    repeat (3)
      idle = (idle << 1) | int'(lfsr_step());
    repeat (idle + 1)
      @(posedge INPUT_CLK);
  endtask

  initial
  begin
    wait (cycle_limit > 0);
    while (cycle_cnt < cycle_limit)
    begin
      @(posedge INPUT_CLK);
      cycle_cnt++;
    end
    $display("Run did not finish within %0d cycles", cycle_limit);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial
  begin
    bit ok;
    $timeformat(-9, 1, "", 0);
    RST            = 1'b1;
    refresh_strobe = 1'b0;
    rand_req       = 1'b0;
    rand_we        = 1'b0;
    rand_addr      = '0;
    rand_mask      = '0;
    bulk_req       = 1'b0;
    bulk_we        = 1'b0;
    bulk_addr      = '0;
    bulk_mask      = '0;
    load_cases(ok);
    if (!ok)
    begin
      $display("No cases could be read from sim/sched_cases.txt");
      $display("SOME TESTS FAILED");
    end
    else
    begin
      cycle_limit = 40 * kind_q.size() + 100;
      repeat (4)
        @(posedge INPUT_CLK);
      RST        <= 1'b0;
      monitor_on  = 1'b1;
      for (int i = 0; i < kind_q.size(); i++)
        run_case(i);
      if (obs_q.size() > 0)
      begin
        $display("Commands appeared on the bus after the last case ended");
        error_count++;
      end
      $display("Cases passed %0d, failed %0d, errors %0d", pass_cases, fail_cases,
               error_count);
      if (fail_cases == 0 && error_count == 0)
        $display("ALL TESTS PASSED");
      else
        $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== design/sdram_sched_top.sv ====
module sdram_sched_top (
  input  logic                               INPUT_CLK,
  input  logic                               RST,
  input  logic                               refresh_strobe,
  input  logic                               rand_req,
  input  logic                               rand_we,
  input  logic [sdram_sched_pkg::ADDR_W-1:0] rand_addr,
  input  sdram_sched_pkg::mask_t             rand_mask,
  input  logic                               bulk_req,
  input  logic                               bulk_we,
  input  logic [sdram_sched_pkg::ADDR_W-1:0] bulk_addr,
  input  sdram_sched_pkg::mask_t             bulk_mask,
  output sdram_sched_pkg::sdram_cmd_e        command,
  output sdram_sched_pkg::sdram_addr_t       address,
  output sdram_sched_pkg::bank_t             bank,
  output sdram_sched_pkg::mask_t             we_array,
  output logic                               grant_rand,
  output logic                               grant_bulk
);

  import sdram_sched_pkg::*;

  logic       issue;
  sdram_cmd_e issue_cmd;
  logic       ready;

  sdram_req_if req_bus ();         // Selected request

  request_select u_request_select (
    .INPUT_CLK  (INPUT_CLK),
    .RST        (RST),
    .rand_req   (rand_req),
    .rand_we    (rand_we),
    .rand_addr  (rand_addr),
    .rand_mask  (rand_mask),
    .bulk_req   (bulk_req),
    .bulk_we    (bulk_we),
    .bulk_addr  (bulk_addr),
    .bulk_mask  (bulk_mask),
    .grant_rand (grant_rand),
    .grant_bulk (grant_bulk),
    .req        (req_bus.src)
  );

  cmd_sequencer u_cmd_sequencer (
    .INPUT_CLK      (INPUT_CLK),
    .RST            (RST),
    .refresh_strobe (refresh_strobe),
    .ready          (ready),
    .req            (req_bus.seq),
    .issue          (issue),
    .issue_cmd      (issue_cmd)
  );

  cmd_timing_guard u_cmd_timing_guard (
    .INPUT_CLK (INPUT_CLK),
    .RST       (RST),
    .issue     (issue),
    .issue_cmd (issue_cmd),
    .ready     (ready)
  );

  cmd_output u_cmd_output (
    .INPUT_CLK  (INPUT_CLK),
    .RST        (RST),
    .issue      (issue),
    .issue_cmd  (issue_cmd),
    .req        (req_bus.out),
    .command    (command),
    .address    (address),
    .bank       (bank),
    .we_array   (we_array),
    .grant_rand (grant_rand),
    .grant_bulk (grant_bulk)
  );

endmodule

// ==== design/cmd_output.sv ====
module cmd_output (
  input  logic                         INPUT_CLK,
  input  logic                         RST,
  input  logic                         issue,
  input  sdram_sched_pkg::sdram_cmd_e  issue_cmd,
  sdram_req_if.out                     req,
  output sdram_sched_pkg::sdram_cmd_e  command,
  output sdram_sched_pkg::sdram_addr_t address,
  output sdram_sched_pkg::bank_t       bank,
  output sdram_sched_pkg::mask_t       we_array,
  output logic                         grant_rand,
  output logic                         grant_bulk
);

  import sdram_sched_pkg::*;

  logic is_access;

  assign is_access = issue && ((issue_cmd == READ) || (issue_cmd == WRTE));

  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
    begin
      command    <= NOOP;
      grant_rand <= 1'b0;
      grant_bulk <= 1'b0;
    end
    else
    begin
      command    <= issue ? issue_cmd : NOOP;
      grant_rand <= is_access && !req.from_bulk;   // Same cycle as READ/WRTE
      grant_bulk <= is_access && req.from_bulk;
    end
  end

  // --------------------------------------------------
  // Address, bank and mask payload
  // --------------------------------------------------
  always_ff @(posedge INPUT_CLK)
  begin
    if (issue)
    begin
      case (issue_cmd)
        ACTV:
        begin
          address <= req.row;
          bank    <= req.bank;
        end
        READ, WRTE:
        begin
          address  <= sdram_addr_t'({req.col, 1'b0});   // Two words per burst
          bank     <= req.bank;
          we_array <= req.mask;
        end
        PRCH:
        begin
          address <= PRCH_ALL_ADDR;
          bank    <= '0;
        end
        default:
        begin
          address <= ARSR_ADDR;
          bank    <= '0;
        end
      endcase
    end
  end

  // One port per access, and each grant lasts one cycle
  a_grant_pulse : assert property (@(posedge INPUT_CLK) disable iff (RST)
    (grant_rand || grant_bulk) |-> !(grant_rand && grant_bulk) ##1
      !(grant_rand || grant_bulk));

endmodule

// ==== design/cmd_timing_guard.sv ====
module cmd_timing_guard (
  input  logic                        INPUT_CLK,
  input  logic                        RST,
  input  logic                        issue,
  input  sdram_sched_pkg::sdram_cmd_e issue_cmd,
  output logic                        ready
);

  import sdram_sched_pkg::*;

  logic [GAP_CNT_W-1:0] gap;
  logic [GAP_CNT_W-1:0] cnt;

  always_comb
  begin
    case (issue_cmd)
      ACTV:    gap = GAP_ACTV;
      READ:    gap = GAP_READ;
      WRTE:    gap = GAP_WRTE;
      PRCH:    gap = GAP_PRCH;
      ARSR:    gap = GAP_ARSR;
      default: gap = GAP_CNT_W'(1);
    endcase
  end

  // Output lags the issue by one cycle, so load one less than the gap
  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
      cnt <= '0;
    else if (issue)
      cnt <= gap - GAP_CNT_W'(1);
    else if (cnt != '0)
      cnt <= cnt - GAP_CNT_W'(1);
  end

  assign ready = (cnt == '0);

endmodule

// ==== design/cmd_sequencer.sv ====
module cmd_sequencer (
  input  logic                        INPUT_CLK,
  input  logic                        RST,
  input  logic                        refresh_strobe,
  input  logic                        ready,
  sdram_req_if.seq                    req,
  output logic                        issue,
  output sdram_sched_pkg::sdram_cmd_e issue_cmd
);

  import sdram_sched_pkg::*;

  logic  page_open;
  page_t open_page;
  logic  refresh_ack;
  logic  refresh_due;
  logic  page_hit;

  assign refresh_due = refresh_strobe != refresh_ack;   // Toggle not yet served
  assign page_hit    = page_open && ({req.row, req.bank} == open_page);

  // --------------------------------------------------
  // Next command choice
  // --------------------------------------------------
  always_comb
  begin
    issue     = 1'b0;
    issue_cmd = NOOP;
    if (ready)
    begin
      if (refresh_due)
      begin
        issue     = 1'b1;
        issue_cmd = page_open ? PRCH : ARSR;   // Close page before refresh
      end
      else if (req.valid)
      begin
        issue = 1'b1;
        if (page_hit)
          issue_cmd = req.write ? WRTE : READ;
        else if (page_open)
          issue_cmd = PRCH;                    // Wrong row or bank
        else
          issue_cmd = ACTV;
      end
    end
  end

  // --------------------------------------------------
  // Page and refresh bookkeeping
  // --------------------------------------------------
  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
    begin
      page_open   <= 1'b0;
      refresh_ack <= refresh_strobe;
    end
    else if (issue)
    begin
      case (issue_cmd)
        ACTV:    page_open   <= 1'b1;
        PRCH:    page_open   <= 1'b0;
        ARSR:    refresh_ack <= refresh_strobe;
        default: page_open   <= page_open;
      endcase
    end
  end

  always_ff @(posedge INPUT_CLK)
  begin
    if (issue && (issue_cmd == ACTV))
      open_page <= {req.row, req.bank};
  end

  // Guard holds off the next command right after an issue
  a_no_issue_in_gap : assert property (@(posedge INPUT_CLK) disable iff (RST)
    issue |=> (!ready && !issue));

endmodule

// ==== design/request_select.sv ====
module request_select (
  input  logic                               INPUT_CLK,
  input  logic                               RST,
  input  logic                               rand_req,
  input  logic                               rand_we,
  input  logic [sdram_sched_pkg::ADDR_W-1:0] rand_addr,
  input  sdram_sched_pkg::mask_t             rand_mask,
  input  logic                               bulk_req,
  input  logic                               bulk_we,
  input  logic [sdram_sched_pkg::ADDR_W-1:0] bulk_addr,
  input  sdram_sched_pkg::mask_t             bulk_mask,
  input  logic                               grant_rand,
  input  logic                               grant_bulk,
  sdram_req_if.src                           req
);

  import sdram_sched_pkg::*;

  logic              rand_req_q;
  logic              rand_we_q;
  logic [ADDR_W-1:0] rand_addr_q;
  mask_t             rand_mask_q;
  logic              bulk_req_q;
  logic              bulk_we_q;
  logic [ADDR_W-1:0] bulk_addr_q;
  mask_t             bulk_mask_q;

  logic              own_grant;
  logic [ADDR_W-1:0] pick_addr;

  assign own_grant = req.from_bulk ? grant_bulk : grant_rand;
  assign pick_addr = bulk_req_q ? bulk_addr_q : rand_addr_q;   // Bulk wins

  // --------------------------------------------------
  // Port sampling and selection control
  // --------------------------------------------------
  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
    begin
      rand_req_q    <= 1'b0;
      bulk_req_q    <= 1'b0;
      req.valid     <= 1'b0;
      req.from_bulk <= 1'b0;
    end
    else
    begin
      // A granted port still shows its request for one more cycle
      rand_req_q <= rand_req && !grant_rand;
      bulk_req_q <= bulk_req && !grant_bulk;
      if (req.valid)
      begin
        if (own_grant)
          req.valid <= 1'b0;
      end
      else if (bulk_req_q || rand_req_q)
      begin
        req.valid     <= 1'b1;
        req.from_bulk <= bulk_req_q;
      end
    end
  end

  always_ff @(posedge INPUT_CLK)
  begin
    rand_we_q   <= rand_we;
    rand_addr_q <= rand_addr;
    rand_mask_q <= rand_mask;
    bulk_we_q   <= bulk_we;
    bulk_addr_q <= bulk_addr;
    bulk_mask_q <= bulk_mask;
    if (!req.valid)                // Frozen while served
    begin
      req.write <= bulk_req_q ? bulk_we_q : rand_we_q;
      req.mask  <= bulk_req_q ? bulk_mask_q : rand_mask_q;
      req.row   <= pick_addr[ADDR_W-1 -: ROW_W];
      req.bank  <= pick_addr[COL_W +: BANK_W];
      req.col   <= pick_addr[COL_W-1:0];
    end
  end

  // Any grant during a held request belongs to its own port
  a_valid_until_grant : assert property (@(posedge INPUT_CLK) disable iff (RST)
    (req.valid && (grant_rand || grant_bulk)) |-> own_grant);

endmodule

// ==== design/sdram_req_if.sv ====
interface sdram_req_if;

  import sdram_sched_pkg::*;

  logic  valid;
  logic  write;
  row_t  row;
  bank_t bank;
  col_t  col;
  mask_t mask;
  logic  from_bulk;                // Port that owns the request

  modport src (
    output valid, write, row, bank, col, mask, from_bulk
  );

  modport seq (
    input valid, write, row, bank
  );

  modport out (
    input row, bank, col, mask, from_bulk
  );

endinterface

// ==== design/sdram_sched_pkg.sv ====
package sdram_sched_pkg;

  // --------------------------------------------------
  // Command encodings on the SDRAM command bus
  // --------------------------------------------------
  typedef enum logic [2:0] {
    NOOP = 3'b111,
    ACTV = 3'b011,                 // Row open
    READ = 3'b101,
    WRTE = 3'b100,
    PRCH = 3'b010,                 // Row close
    ARSR = 3'b001                  // Auto refresh
  } sdram_cmd_e;

  // --------------------------------------------------
  // Client word address layout
  // --------------------------------------------------
  localparam int ADDR_W = 26;
  localparam int ROW_W  = 14;      // Bits 25..12
  localparam int BANK_W = 3;       // Bits 11..9
  localparam int COL_W  = 9;       // Bits 8..0
  localparam int MASK_W = 4;

  typedef logic [ROW_W-1:0]        row_t;
  typedef logic [BANK_W-1:0]       bank_t;
  typedef logic [COL_W-1:0]        col_t;
  typedef logic [ROW_W+BANK_W-1:0] page_t;   // Row then bank
  typedef logic [MASK_W-1:0]       mask_t;
  typedef logic [ROW_W-1:0]        sdram_addr_t;

  localparam sdram_addr_t PRCH_ALL_ADDR = sdram_addr_t'(14'h0400);  // A10 high
  localparam sdram_addr_t ARSR_ADDR     = '0;

  // --------------------------------------------------
  // Minimum spacing after each command, in cycles
  // --------------------------------------------------
  localparam int GAP_CNT_W = 4;

  localparam logic [GAP_CNT_W-1:0] GAP_ACTV = GAP_CNT_W'(3);
  localparam logic [GAP_CNT_W-1:0] GAP_READ = GAP_CNT_W'(4);
  localparam logic [GAP_CNT_W-1:0] GAP_WRTE = GAP_CNT_W'(6);   // Covers write recovery
  localparam logic [GAP_CNT_W-1:0] GAP_PRCH = GAP_CNT_W'(3);
  localparam logic [GAP_CNT_W-1:0] GAP_ARSR = GAP_CNT_W'(8);

endpackage
